// File: vlog.f
+incdir+hdl
hdl/relay_pkg.sv
hdl/sequencer.sv
hdl/instruction_decoder.sv
hdl/register_file.sv
hdl/alu.sv
hdl/address_unit.sv
hdl/memory.sv
hdl/relay_computer.sv
tb/tb_relay_computer.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the relay computer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_relay_computer \
  -f vlog.f -o tb_relay_computer > build.log 2>&1 \
  && ./obj_dir/tb_relay_computer > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "TEST FAILED" sim.log && { echo "simulation reported a failure, see sim.log"; exit 1; } \
  || { echo "simulation finished without failures"; exit 0; }

// File: tb/tb_relay_computer.sv
`timescale 1ns/1ps

module tb_relay_computer;
  import relay_pkg::*;

  localparam logic [7:0] OP_INC16   = 8'hB0;
  localparam logic [7:0] OP_HALT    = 8'hAE;
  localparam int         MAX_CLOCKS = 4000;  // per program run

  logic        clock;
  logic        arst_n;
  logic        run;
  logic        prog_we;
  logic [15:0] prog_addr;
  logic [7:0]  prog_data;
  logic        halted;
  logic        instr_done;
  panel_t      panel;

  logic [15:0] img_addr[$];  // program image, address and byte
  logic [7:0]  img_data[$];
  logic [7:0]  done_inst[$]; // INST seen at each instr_done
  logic [15:0] org;
  logic [31:0] rng_state;
  int          done_count = 0;
  int          tests;
  int          checks;
  int          errors;
  int          test_errors;
  string       cur_test;

  relay_computer u_relay_computer (
    .clock, .arst_n, .run, .prog_we, .prog_addr, .prog_data,
    .halted, .instr_done, .panel
  );

  always #50 clock = ~clock;

  always @(negedge clock)
    if (instr_done) begin
      done_count++;  // mid-cycle, pulse is stable here
      done_inst.push_back(panel.inst);
    end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] sext5(input logic [4:0] imm);
    return {{3{imm[4]}}, imm};
  endfunction

  // result in [7:0], carry out in [8]
  function automatic logic [8:0] alu_ref(input alu_fn_e fn, input logic [7:0] b,
                                         input logic [7:0] c);
    case (fn)
      FN_ADD:  return {1'b0, b} + {1'b0, c};
      FN_INC:  return {1'b0, b} + 9'd1;
      FN_AND:  return {1'b0, b & c};
      FN_OR:   return {1'b0, b | c};
      FN_XOR:  return {1'b0, b ^ c};
      FN_NOT:  return {1'b0, ~b};
      FN_SHL:  return {1'b0, b[6:0], b[7]};
      default: return 9'd0;
    endcase
  endfunction

  function automatic ccr_t flags_of(input logic [8:0] r);
    ccr_t f;
    f.sign  = r[7];
    f.carry = r[8];
    f.zero  = r[7:0] == 8'h00;
    return f;
  endfunction

  // mask is {sign, carry, zero, not-zero}
  function automatic logic goto_taken(input logic [3:0] mask, input ccr_t f);
    if (mask == 4'b0000)
      return 1'b1;
    return (mask[3] && f.sign) || (mask[2] && f.carry) ||
           (mask[1] && f.zero) || (mask[0] && !f.zero);
  endfunction

  function automatic logic [7:0] mov8_byte(input reg8_e dst, input reg8_e src);
    return {2'b00, dst, src};
  endfunction

  function automatic logic [7:0] setab_byte(input logic rb, input logic [4:0] imm);
    return {2'b01, rb, imm};
  endfunction

  function automatic logic [7:0] alu_byte(input logic dst, input alu_fn_e fn);
    return {4'b1000, dst, fn};
  endfunction

  function automatic logic [7:0] load_byte(input logic [1:0] rg);
    return {6'b100100, rg};
  endfunction

  function automatic logic [7:0] store_byte(input logic [1:0] rg);
    return {6'b100110, rg};
  endfunction

  // src 0 = M, 1 = XY, 2 = J
  function automatic logic [7:0] mov16_byte(input logic to_pc, input logic [1:0] src);
    return {5'b10100, to_pc, src};
  endfunction

  function automatic logic [7:0] goto_byte(input logic to_j, input logic [3:0] mask,
                                           input logic link);
    return {2'b11, to_j, mask, link};
  endfunction

  task automatic clear_image();
    img_addr.delete();
    img_data.delete();
    org = 16'h0000;
  endtask

  task automatic emit(input logic [7:0] b);
    img_addr.push_back(org);
    img_data.push_back(b);
    org = org + 16'd1;
  endtask

  // reset, load the image with run low, then run until halted
  task automatic run_image(output int executed);
    int n;
    int start;
    @(posedge clock);
    arst_n <= 1'b0;
    run    <= 1'b0;
    repeat (4) @(posedge clock);
    arst_n <= 1'b1;
    foreach (img_data[i]) begin
      @(posedge clock);
      prog_we   <= 1'b1;
      prog_addr <= img_addr[i];
      prog_data <= img_data[i];
    end
    @(posedge clock);
    prog_we <= 1'b0;
    run     <= 1'b1;
    start   = done_count;
    done_inst.delete();
    n       = 0;
    while (!halted && n < MAX_CLOCKS) begin
      @(negedge clock);
      n++;
    end
    if (!halted) begin
      $display("test %s: the computer did not halt within %0d clocks", cur_test, MAX_CLOCKS);
      errors++;
      test_errors++;
    end
    executed = done_count - start;
    @(posedge clock);
    run <= 1'b0;
  endtask

  task automatic check8(input string what, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("error %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check16(input string what, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("error %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_ccr(input string what, input ccr_t exp, input ccr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("error %s %s: expected scz %b actual scz %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      test_errors++;
      $display("error %s %s: expected %0d actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
    tests++;
  endtask

  task automatic end_test();
    if (test_errors == 0)
      $display("test %s: ok", cur_test);
    else
      $display("test %s: %0d errors", cur_test, test_errors);
  endtask

  task automatic test_setab_mov8();
    logic [4:0] ai;
    logic [4:0] bi;
    int         executed;
    ai = 5'h0b;  // positive
    bi = 5'h15;  // negative
    begin_test("setab_mov8");
    clear_image();
    emit(setab_byte(1'b0, ai));
    emit(setab_byte(1'b1, bi));
    emit(mov8_byte(REG_C, REG_A));
    emit(mov8_byte(REG_D, REG_B));
    emit(mov8_byte(REG_M1, REG_C));
    emit(mov8_byte(REG_M2, REG_D));
    emit(mov8_byte(REG_X, REG_M1));
    emit(mov8_byte(REG_Y, REG_M2));
    emit(mov8_byte(REG_C, REG_Y));
    emit(mov8_byte(REG_D, REG_X));
    emit(mov8_byte(REG_B, REG_X));
    emit(mov8_byte(REG_A, REG_A));  // equal codes clear A
    emit(OP_HALT);
    run_image(executed);
    check8("a", 8'h00, panel.a);
    check8("b", sext5(ai), panel.b);
    check8("c", sext5(bi), panel.c);
    check8("d", sext5(ai), panel.d);
    check8("m1", sext5(ai), panel.m1);
    check8("m2", sext5(bi), panel.m2);
    check8("x", sext5(ai), panel.x);
    check8("y", sext5(bi), panel.y);
    check_count("instr_done", 13, executed);
    // straight-line code, INST follows the image byte by byte
    foreach (img_data[i])
      check8($sformatf("inst %0d", i), img_data[i], done_inst[i]);
    end_test();
  endtask

  task automatic test_alu();
    alu_fn_e    fn;
    logic       dst;
    logic [8:0] r;
    int         executed;
    begin_test("alu");
    for (int f = 0; f < 8; f++) begin
      fn  = alu_fn_e'(f);
      dst = !f[0];  // even functions into D
      r   = alu_ref(fn, sext5(5'h15), sext5(5'h0c));
      clear_image();
      emit(setab_byte(1'b0, 5'h0c));
      emit(mov8_byte(REG_C, REG_A));
      emit(setab_byte(1'b1, 5'h15));
      emit(alu_byte(dst, fn));
      emit(OP_HALT);
      run_image(executed);
      check8($sformatf("%s result", fn.name()), r[7:0], dst ? panel.d : panel.a);
      check_ccr($sformatf("%s ccr", fn.name()), flags_of(r), panel.ccr);
    end
    end_test();
  endtask

  task automatic test_load_store();
    logic [4:0] va, vb, vc, vd;
    reg8_e      srcs[4];
    int         executed;
    va      = 5'h07;
    vb      = 5'h1a;
    vc      = 5'h13;
    vd      = 5'h05;
    srcs[0] = REG_X;   // M = 0x0108
    srcs[1] = REG_Y;   // M = 0x010c
    srcs[2] = REG_M2;  // cleared, M = 0x0100
    srcs[3] = REG_M1;  // M = 0x0101
    begin_test("load_store");
    clear_image();
    emit(setab_byte(1'b0, 5'h01));
    emit(mov8_byte(REG_M1, REG_A));
    emit(setab_byte(1'b0, 5'h08));
    emit(mov8_byte(REG_X, REG_A));
    emit(setab_byte(1'b0, 5'h0c));
    emit(mov8_byte(REG_Y, REG_A));
    emit(setab_byte(1'b0, vc));
    emit(mov8_byte(REG_C, REG_A));
    emit(setab_byte(1'b0, vd));
    emit(mov8_byte(REG_D, REG_A));
    emit(setab_byte(1'b0, va));
    emit(setab_byte(1'b1, vb));
    for (int i = 0; i < 4; i++) begin
      emit(mov8_byte(REG_M2, srcs[i]));
      emit(store_byte(2'(i)));
    end
    for (int i = 0; i < 4; i++) begin
      emit(mov8_byte(REG_M2, srcs[i]));
      emit(load_byte(2'((i + 3) % 4)));  // back into a different register
    end
    emit(OP_HALT);
    run_image(executed);
    check8("a", sext5(vb), panel.a);
    check8("b", sext5(vc), panel.b);
    check8("c", sext5(vd), panel.c);
    check8("d", sext5(va), panel.d);
    check16("m", 16'h0101, {panel.m1, panel.m2});
    check_count("instr_done", 29, executed);
    end_test();
  endtask

  task automatic test_mov16_inc16();
    int executed;
    begin_test("mov16_inc16");
    clear_image();
    emit(setab_byte(1'b0, 5'h01));
    emit(mov8_byte(REG_M1, REG_A));
    emit(setab_byte(1'b0, 5'h0f));
    emit(mov8_byte(REG_M2, REG_A));
    emit(mov16_byte(1'b0, 2'd0));  // XY from M
    emit(mov16_byte(1'b1, 2'd1));  // PC from XY
    emit(OP_HALT);
    org = 16'h010f;
    emit(setab_byte(1'b1, 5'h09));  // marker, jump landed
    emit(OP_HALT);
    run_image(executed);
    check16("xy", 16'h010f, {panel.x, panel.y});
    check8("marker b", 8'h09, panel.b);
    check16("pc after jump", 16'h0111, panel.pc);
    check_count("instr_done after jump", 8, executed);
    clear_image();
    emit(setab_byte(1'b0, 5'h1f));
    emit(mov8_byte(REG_Y, REG_A));
    emit(mov8_byte(REG_X, REG_X));
    emit(OP_INC16);
    emit(OP_HALT);
    run_image(executed);
    check16("xy after inc16", 16'h0100, {panel.x, panel.y});
    check16("pc after inc16", 16'h0005, panel.pc);
    end_test();
  endtask

  task automatic run_goto_case(input logic [4:0] bi, input alu_fn_e fn, input logic to_j,
                               input logic [3:0] mask, input logic link);
    ccr_t        fl;
    logic        tk;
    logic [15:0] tgt;
    string       tag;
    int          executed;
    tgt = 16'h0040;
    fl  = flags_of(alu_ref(fn, sext5(bi), 8'h00));
    tk  = goto_taken(mask, fl);
    tag = $sformatf("%s mask %b link %b", fn.name(), mask, link);
    clear_image();
    emit(setab_byte(1'b1, bi));
    emit(alu_byte(1'b1, fn));
    emit(goto_byte(to_j, mask, link));
    emit(tgt[15:8]);  // high byte first
    emit(tgt[7:0]);
    emit(setab_byte(1'b0, 5'h02));  // not taken marker
    emit(OP_HALT);
    org = tgt;
    emit(setab_byte(1'b0, 5'h05));  // taken marker
    emit(OP_HALT);
    run_image(executed);
    check8({tag, " marker"}, tk ? 8'h05 : 8'h02, panel.a);
    check16({tag, " pc"}, tk ? tgt + 16'd2 : 16'h0007, panel.pc);
    check16({tag, " xy"}, (tk && link) ? 16'h0005 : 16'h0000, {panel.x, panel.y});
    if (to_j)
      check16({tag, " j"}, tgt, {panel.j1, panel.j2});
    else
      check16({tag, " m"}, tgt, {panel.m1, panel.m2});
    check_ccr({tag, " ccr"}, fl, panel.ccr);
    check_count({tag, " instr_done"}, 5, executed);
  endtask

  task automatic test_goto();
    logic [4:0] bi;
    alu_fn_e    fn;
    begin_test("goto");
    run_goto_case(5'h01, FN_INC, 1'b1, 4'b0000, 1'b1);
    run_goto_case(5'h01, FN_INC, 1'b0, 4'b0000, 1'b0);
    // flags 000, then carry and zero, then sign
    for (int s = 0; s < 3; s++) begin
      bi = (s == 1) ? 5'h1f : 5'h01;
      fn = (s == 2) ? FN_NOT : FN_INC;
      for (int m = 0; m < 4; m++)
        run_goto_case(bi, fn, 1'b1, 4'(1 << m), m[0]);
    end
    end_test();
  endtask

  task automatic test_random_alu();
    logic [4:0] bi;
    logic [4:0] ci;
    alu_fn_e    fn;
    logic       dst;
    logic [8:0] r;
    int         executed;
    begin_test("random_alu");
    for (int k = 0; k < 20; k++) begin
      rng_state = xorshift(rng_state);
      bi        = rng_state[4:0];
      ci        = rng_state[9:5];
      fn        = alu_fn_e'(rng_state[12:10]);
      dst       = rng_state[13];
      r         = alu_ref(fn, sext5(bi), sext5(ci));
      clear_image();
      emit(setab_byte(1'b0, ci));
      emit(mov8_byte(REG_C, REG_A));
      emit(setab_byte(1'b1, bi));
      emit(alu_byte(dst, fn));
      emit(OP_HALT);
      run_image(executed);
      check8($sformatf("pair %0d %s", k, fn.name()), r[7:0], dst ? panel.d : panel.a);
      check_ccr($sformatf("pair %0d ccr", k), flags_of(r), panel.ccr);
      check_count($sformatf("pair %0d instr_done", k), 5, executed);
    end
    end_test();
  endtask

  initial begin
    clock     = 1'b0;
    arst_n    = 1'b0;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = 16'h0000;
    prog_data = 8'h00;
    rng_state = 32'he78d;
    tests     = 0;
    checks    = 0;
    errors    = 0;
    test_setab_mov8();
    test_alu();
    test_load_store();
    test_mov16_inc16();
    test_goto();
    test_random_alu();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/relay_computer.sv
`timescale 1ns/1ps
`include "relay_defs.svh"

module relay_computer (
  input  logic                     clock,
  input  logic                     arst_n,
  input  logic                     run,
  input  logic                     prog_we,
  input  logic [`RELAY_ADDR_W-1:0] prog_addr,
  input  logic [`RELAY_DATA_W-1:0] prog_data,
  output logic                     halted,
  output logic                     instr_done,
  output relay_pkg::panel_t        panel
);
  import relay_pkg::*;

  logic [`RELAY_STEPS-1:0]  fsa_out, fsa_out_prime;
  abort_e                   abort_sel;
  logic                     halt;
  ctrl_bus_t                control;
  instr_u                   inst_reg;
  ccr_t                     ccr;
  panel_t                   panel_regs;
  logic [`RELAY_DATA_W-1:0] data_bus, mem_rdata, alu_result, b_val, c_val;
  logic [`RELAY_ADDR_W-1:0] addr_bus, m_val, j_val, pc, xy;

  sequencer u_sequencer (
    .clock, .arst_n, .run, .abort_sel, .halt,
    .fsa_out, .fsa_out_prime, .instr_done, .halted
  );

  instruction_decoder u_instruction_decoder (
    .clock, .arst_n, .inst_reg, .fsa_out, .fsa_out_prime, .ccr,
    .control, .abort_sel, .halt
  );

  register_file u_register_file (
    .clock, .arst_n, .control, .mem_rdata, .alu_result,
    .xy_val(xy), .data_bus, .inst_reg, .b_val, .c_val, .m_val, .j_val,
    .panel_regs
  );

  alu u_alu (
    .clock, .arst_n, .control, .b_val, .c_val,
    .result(alu_result), .ccr
  );

  address_unit u_address_unit (
    .clock, .arst_n, .control, .m_val, .j_val, .data_bus,
    .addr_bus, .pc, .xy
  );

  memory u_memory (
    .clock, .control, .addr_bus, .data_bus,
    .prog_we, .prog_addr, .prog_data, .rdata(mem_rdata)
  );

  // panel view, pc and flags come from outside the register file
  always_comb begin
    panel     = panel_regs;
    panel.pc  = pc;
    panel.ccr = ccr;
  end

endmodule

// File: hdl/memory.sv
`timescale 1ns/1ps
`include "relay_defs.svh"

module memory (
  input  logic                     clock,
  input  relay_pkg::ctrl_bus_t     control,
  input  logic [`RELAY_ADDR_W-1:0] addr_bus,
  input  logic [`RELAY_DATA_W-1:0] data_bus,
  input  logic                     prog_we,
  input  logic [`RELAY_ADDR_W-1:0] prog_addr,
  input  logic [`RELAY_DATA_W-1:0] prog_data,
  output logic [`RELAY_DATA_W-1:0] rdata
);
  localparam int AW = $clog2(`RELAY_MEM_WORDS);

  logic [`RELAY_DATA_W-1:0] mem [`RELAY_MEM_WORDS];

  always_ff @(posedge clock) begin
    if (prog_we)
      mem[prog_addr[AW-1:0]] <= prog_data;  // loader, only while run is low
    else if (control.mem_write)
      mem[addr_bus[AW-1:0]] <= data_bus;
  end

  assign rdata = control.mem_read ? mem[addr_bus[AW-1:0]] : '0;

endmodule

// File: hdl/address_unit.sv
`timescale 1ns/1ps
`include "relay_defs.svh"

module address_unit (
  input  logic                     clock,
  input  logic                     arst_n,
  input  relay_pkg::ctrl_bus_t     control,
  input  logic [`RELAY_ADDR_W-1:0] m_val,
  input  logic [`RELAY_ADDR_W-1:0] j_val,
  input  logic [`RELAY_DATA_W-1:0] data_bus,
  output logic [`RELAY_ADDR_W-1:0] addr_bus,
  output logic [`RELAY_ADDR_W-1:0] pc,
  output logic [`RELAY_ADDR_W-1:0] xy
);
  import relay_pkg::*;

  logic [`RELAY_ADDR_W-1:0] inc_q;

  always_comb begin
    addr_bus = '0;
    if (control.pc.sel)  addr_bus |= pc;
    if (control.inc.sel) addr_bus |= inc_q;
    if (control.xy.sel)  addr_bus |= xy;
    if (control.m_sel)   addr_bus |= m_val;
    if (control.j_sel)   addr_bus |= j_val;
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pc    <= '0;
      inc_q <= '0;
      xy    <= '0;
    end else begin
      if (control.pc.ld)  pc    <= addr_bus;
      if (control.inc.ld) inc_q <= addr_bus + 1'b1;  // 16-bit incrementer
      // XY takes a whole word or single bytes from MOV8
      if (control.xy.ld)
        xy <= addr_bus;
      else begin
        if (control.r8[REG_X].ld) xy[15:8] <= data_bus;
        if (control.r8[REG_Y].ld) xy[7:0]  <= data_bus;
      end
    end
  end

  a_addr_one_src: assert property (@(posedge clock) disable iff (!arst_n)
    $onehot0({control.pc.sel, control.inc.sel, control.xy.sel,
              control.m_sel, control.j_sel}));

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps
`include "relay_defs.svh"

module alu (
  input  logic                     clock,
  input  logic                     arst_n,
  input  relay_pkg::ctrl_bus_t     control,
  input  logic [`RELAY_DATA_W-1:0] b_val,
  input  logic [`RELAY_DATA_W-1:0] c_val,
  output logic [`RELAY_DATA_W-1:0] result,
  output relay_pkg::ccr_t          ccr
);
  import relay_pkg::*;

  logic [`RELAY_DATA_W:0] sum;  // with carry out
  logic                   carry;

  always_comb begin
    sum   = '0;
    carry = 1'b0;
    case (control.alu_fn)
      FN_ADD: begin
        sum    = {1'b0, b_val} + {1'b0, c_val};
        result = sum[`RELAY_DATA_W-1:0];
        carry  = sum[`RELAY_DATA_W];
      end
      FN_INC: begin
        sum    = {1'b0, b_val} + 1'b1;
        result = sum[`RELAY_DATA_W-1:0];
        carry  = sum[`RELAY_DATA_W];
      end
      FN_AND:  result = b_val & c_val;
      FN_OR:   result = b_val | c_val;
      FN_XOR:  result = b_val ^ c_val;
      FN_NOT:  result = ~b_val;
      FN_SHL:  result = {b_val[`RELAY_DATA_W-2:0], b_val[`RELAY_DATA_W-1]};  // rotate
      default: result = '0;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ccr <= '0;
    end else if (control.ccr_load) begin
      ccr.sign  <= result[`RELAY_DATA_W-1];
      ccr.carry <= carry;
      ccr.zero  <= result == '0;
    end
  end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps
`include "relay_defs.svh"

module register_file (
  input  logic                     clock,
  input  logic                     arst_n,
  input  relay_pkg::ctrl_bus_t     control,
  input  logic [`RELAY_DATA_W-1:0] mem_rdata,
  input  logic [`RELAY_DATA_W-1:0] alu_result,
  input  logic [`RELAY_ADDR_W-1:0] xy_val,
  output logic [`RELAY_DATA_W-1:0] data_bus,
  output relay_pkg::instr_u        inst_reg,
  output logic [`RELAY_DATA_W-1:0] b_val,
  output logic [`RELAY_DATA_W-1:0] c_val,
  output logic [`RELAY_ADDR_W-1:0] m_val,
  output logic [`RELAY_ADDR_W-1:0] j_val,
  output relay_pkg::panel_t        panel_regs
);
  import relay_pkg::*;

  logic [`RELAY_DATA_W-1:0] r_q [0:5];   // A, B, C, D, M1, M2
  logic [`RELAY_DATA_W-1:0] val [0:7];   // by reg8_e, X and Y live in the XY pair
  logic [`RELAY_DATA_W-1:0] j1_q, j2_q;
  logic [`RELAY_DATA_W-1:0] imm_ext;

  assign imm_ext = {{3{inst_reg.setab.imm[4]}}, inst_reg.setab.imm};

  always_comb begin
    for (int i = 0; i < 6; i++)
      val[i] = r_q[i];
    val[REG_X] = xy_val[15:8];
    val[REG_Y] = xy_val[7:0];
  end

  // wired-or bus, decoder keeps at most one source on
  always_comb begin
    data_bus = '0;
    for (int i = 0; i < 8; i++)
      if (control.r8[i].sel) data_bus |= val[i];
    if (control.mem_read) data_bus |= mem_rdata;
    if (control.alu_en)   data_bus |= alu_result;
    if (control.imm_sel)  data_bus |= imm_ext;
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 6; i++)
        r_q[i] <= '0;
      j1_q     <= '0;
      j2_q     <= '0;
      inst_reg <= '0;
    end else begin
      for (int i = 0; i < 6; i++)
        if (control.r8[i].ld) r_q[i] <= data_bus;
      if (control.j1_ld)   j1_q     <= data_bus;  // high byte
      if (control.j2_ld)   j2_q     <= data_bus;
      if (control.inst_ld) inst_reg <= data_bus;
    end
  end

  assign b_val = r_q[REG_B];
  assign c_val = r_q[REG_C];
  assign m_val = {r_q[REG_M1], r_q[REG_M2]};
  assign j_val = {j1_q, j2_q};

  always_comb begin
    panel_regs      = '0;  // pc and ccr filled at the top
    panel_regs.a    = r_q[REG_A];
    panel_regs.b    = r_q[REG_B];
    panel_regs.c    = r_q[REG_C];
    panel_regs.d    = r_q[REG_D];
    panel_regs.m1   = r_q[REG_M1];
    panel_regs.m2   = r_q[REG_M2];
    panel_regs.x    = val[REG_X];
    panel_regs.y    = val[REG_Y];
    panel_regs.j1   = j1_q;
    panel_regs.j2   = j2_q;
    panel_regs.inst = inst_reg;
  end

endmodule

// File: hdl/instruction_decoder.sv
`timescale 1ns/1ps
`include "relay_defs.svh"

module instruction_decoder (
  input  logic                    clock,
  input  logic                    arst_n,
  input  relay_pkg::instr_u       inst_reg,
  input  logic [`RELAY_STEPS-1:0] fsa_out,
  input  logic [`RELAY_STEPS-1:0] fsa_out_prime,
  input  relay_pkg::ccr_t         ccr,
  output relay_pkg::ctrl_bus_t    control,
  output relay_pkg::abort_e       abort_sel,
  output logic                    halt
);
  import relay_pkg::*;

  logic p_fetch, p_inst, p_inc, p_inc_ld;
  logic p_e, p_e_ld;
  logic p_9, p_9_ld, p_11, p_11_ld, p_13, p_13_ld;
  logic p_15, p_15_ld, p_17, p_17_ld, p_19, p_19_ld;
  logic is_mov8, is_setab, is_alu, is_load, is_store;
  logic is_mov16, is_inc16, is_goto;
  logic cond_any, taken;
  reg8_e mem_reg;

  // derived pulses
  assign p_fetch  = fsa_out[1] || fsa_out[2];
  assign p_inst   = fsa_out_prime[2];
  assign p_inc    = fsa_out[3];
  assign p_inc_ld = fsa_out_prime[3];
  assign p_e      = fsa_out[5];
  assign p_e_ld   = fsa_out_prime[5];
  assign p_9      = fsa_out[9];
  assign p_9_ld   = fsa_out_prime[9];
  assign p_11     = fsa_out[11];
  assign p_11_ld  = fsa_out_prime[11];
  assign p_13     = fsa_out[13];
  assign p_13_ld  = fsa_out_prime[13];
  assign p_15     = fsa_out[15];
  assign p_15_ld  = fsa_out_prime[15];
  assign p_17     = fsa_out[17];
  assign p_17_ld  = fsa_out_prime[17];
  assign p_19     = fsa_out[19];
  assign p_19_ld  = fsa_out_prime[19];

  // instruction classes
  assign is_mov8  = inst_reg.mov8.op == 2'b00;
  assign is_setab = inst_reg.setab.op == 2'b01;
  assign is_alu   = inst_reg.alu.op == 4'b1000;
  assign is_load  = inst_reg.mem.op == 6'b100100;
  assign is_store = inst_reg.mem.op == 6'b100110;
  assign is_mov16 = inst_reg.mem.op[5:1] == 5'b10100;
  assign is_inc16 = inst_reg == 8'hB0;
  assign halt     = inst_reg == 8'hAE;
  assign is_goto  = inst_reg.goto.op == 2'b11;
  assign mem_reg  = reg8_e'({1'b0, inst_reg.mem.rg});  // A..D only

  // empty mask jumps always
  assign cond_any = inst_reg.goto.c_sign || inst_reg.goto.c_carry ||
                    inst_reg.goto.c_zero || inst_reg.goto.c_nz;
  assign taken = !cond_any ||
                 (inst_reg.goto.c_sign && ccr.sign) ||
                 (inst_reg.goto.c_carry && ccr.carry) ||
                 (inst_reg.goto.c_zero && ccr.zero) ||
                 (inst_reg.goto.c_nz && !ccr.zero);

  always_comb begin
    control   = '0;
    abort_sel = ABORT_8;
    // fetch and increment, every instruction
    control.pc.sel   = p_fetch;
    control.mem_read = p_fetch;
    control.inst_ld  = p_inst;
    control.inc.ld   = p_inst;
    control.inc.sel  = p_inc;
    control.pc.ld    = p_inc_ld;
    if (is_mov8) begin
      if (inst_reg.mov8.src != inst_reg.mov8.dst)  // equal codes clear dst
        control.r8[inst_reg.mov8.src].sel = p_e;
      control.r8[inst_reg.mov8.dst].ld = p_e_ld;
    end else if (is_setab) begin
      control.imm_sel = p_e;
      control.r8[inst_reg.setab.rb ? REG_B : REG_A].ld = p_e_ld;
    end else if (is_alu) begin
      control.alu_en   = p_e;
      control.alu_fn   = inst_reg.alu.fn;
      control.ccr_load = p_e_ld;
      control.r8[inst_reg.alu.dst ? REG_D : REG_A].ld = p_e_ld;
    end else if (is_load) begin
      abort_sel            = ABORT_12;
      control.m_sel        = p_9;
      control.mem_read     = p_fetch || p_9;
      control.r8[mem_reg].ld = p_9_ld;
    end else if (is_store) begin
      abort_sel               = ABORT_12;
      control.m_sel           = p_9;
      control.r8[mem_reg].sel = p_9;
      control.mem_write       = p_9_ld;
    end else if (is_mov16) begin
      abort_sel      = ABORT_12;
      control.m_sel  = p_9 && inst_reg.mem.rg == 2'b00;
      control.xy.sel = p_9 && inst_reg.mem.rg == 2'b01;
      control.j_sel  = p_9 && inst_reg.mem.rg == 2'b10;
      if (inst_reg.mem.op[0])
        control.pc.ld = p_inc_ld || p_9_ld;
      else
        control.xy.ld = p_9_ld;
    end else if (halt) begin
      abort_sel = ABORT_12;
    end else if (is_inc16) begin
      abort_sel       = ABORT_14;
      control.xy.sel  = p_9;
      control.inc.ld  = p_inst || p_9_ld;
      control.inc.sel = p_inc || p_11;
      control.xy.ld   = p_11_ld;
    end else if (is_goto) begin
      abort_sel        = ABORT_24;
      // immediate bytes, high first, PC stepping past each
      control.pc.sel   = p_fetch || p_9 || p_13 || (taken && inst_reg.goto.link && p_17);
      control.mem_read = p_fetch || p_9 || p_13;
      control.inc.ld   = p_inst || p_9_ld || p_13_ld;
      control.inc.sel  = p_inc || p_11 || p_15;
      control.pc.ld    = p_inc_ld || p_11_ld || p_15_ld || (taken && p_19_ld);
      control.xy.ld    = taken && inst_reg.goto.link && p_17_ld;  // link
      if (inst_reg.goto.dst) begin
        control.j1_ld = p_9_ld;
        control.j2_ld = p_13_ld;
        control.j_sel = taken && p_19;
      end else begin
        control.r8[REG_M1].ld = p_9_ld;
        control.r8[REG_M2].ld = p_13_ld;
        control.m_sel         = taken && p_19;
      end
    end
  end

  a_bus_one_src: assert property (@(posedge clock) disable iff (!arst_n)
    $onehot0({control.r8[7].sel, control.r8[6].sel, control.r8[5].sel,
              control.r8[4].sel, control.r8[3].sel, control.r8[2].sel,
              control.r8[1].sel, control.r8[0].sel,
              control.mem_read, control.alu_en, control.imm_sel}));

endmodule

// File: hdl/sequencer.sv
`timescale 1ns/1ps
`include "relay_defs.svh"

module sequencer (
  input  logic                    clock,
  input  logic                    arst_n,
  input  logic                    run,
  input  relay_pkg::abort_e       abort_sel,
  input  logic                    halt,
  output logic [`RELAY_STEPS-1:0] fsa_out,
  output logic [`RELAY_STEPS-1:0] fsa_out_prime,
  output logic                    instr_done,
  output logic                    halted
);
  import relay_pkg::*;

  logic       active;
  logic       half;   // second clock of the step
  logic [4:0] step;
  logic [4:0] len;
  logic       at_end;

  always_comb begin
    case (abort_sel)
      ABORT_8:  len = 5'(`RELAY_LEN_SHORT);
      ABORT_12: len = 5'(`RELAY_LEN_MEM);
      ABORT_14: len = 5'(`RELAY_LEN_INC);
      default:  len = 5'(`RELAY_LEN_GOTO);
    endcase
  end

  assign at_end        = active && half && (step == len - 5'd1);
  assign instr_done    = at_end;
  assign fsa_out       = active ? (`RELAY_STEPS'(1) << step) : '0;
  assign fsa_out_prime = half ? fsa_out : '0;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      active <= 1'b0;
      half   <= 1'b0;
      step   <= '0;
      halted <= 1'b0;
    end else if (active) begin
      half <= !half;
      if (at_end) begin
        step <= '0;
        if (halt) begin
          active <= 1'b0;
          halted <= 1'b1;  // sticky until reset
        end else begin
          active <= run;   // hold between instructions when run drops
        end
      end else if (half) begin
        step <= step + 5'd1;
      end
    end else if (run && !halted) begin
      active <= 1'b1;
      half   <= 1'b0;
      step   <= '0;
    end
  end

  // one step at a time, never past the abort point of the running class
  a_fsa_onehot: assert property (@(posedge clock) disable iff (!arst_n)
    active |-> $onehot(fsa_out) && (step < len));

endmodule

// File: hdl/relay_pkg.sv
`include "relay_defs.svh"

package relay_pkg;

  typedef enum logic [2:0] {
    REG_A  = 3'd0,
    REG_B  = 3'd1,
    REG_C  = 3'd2,
    REG_D  = 3'd3,
    REG_M1 = 3'd4,
    REG_M2 = 3'd5,
    REG_X  = 3'd6,
    REG_Y  = 3'd7
  } reg8_e;

  typedef enum logic [2:0] {
    FN_ADD = 3'd0,
    FN_INC = 3'd1,
    FN_AND = 3'd2,
    FN_OR  = 3'd3,
    FN_XOR = 3'd4,
    FN_NOT = 3'd5,
    FN_SHL = 3'd6,  // rotate left
    FN_CLR = 3'd7
  } alu_fn_e;

  // instruction length class
  typedef enum logic [1:0] {
    ABORT_8  = 2'd0,
    ABORT_12 = 2'd1,
    ABORT_14 = 2'd2,
    ABORT_24 = 2'd3
  } abort_e;

  // one instruction byte, five ways of reading it
  typedef union packed {
    struct packed {logic [1:0] op; reg8_e dst; reg8_e src;} mov8;
    struct packed {logic [1:0] op; logic rb; logic [4:0] imm;} setab;
    struct packed {logic [3:0] op; logic dst; alu_fn_e fn;} alu;
    struct packed {logic [5:0] op; logic [1:0] rg;} mem;
    struct packed {
      logic [1:0] op;
      logic       dst;     // 1 = J, 0 = M
      logic       c_sign;
      logic       c_carry;
      logic       c_zero;
      logic       c_nz;
      logic       link;
    } goto;
  } instr_u;

  typedef struct packed {
    logic sign;
    logic carry;
    logic zero;
  } ccr_t;

  typedef struct packed {
    logic ld;
    logic sel;
  } strobe_t;

  typedef struct packed {
    strobe_t [7:0] r8;      // indexed by reg8_e
    logic          j1_ld;
    logic          j2_ld;
    logic          inst_ld;
    logic          imm_sel; // setab immediate onto data bus
    logic          m_sel;
    logic          j_sel;
    strobe_t       xy;
    strobe_t       pc;
    strobe_t       inc;
    logic          mem_read;
    logic          mem_write;
    logic          ccr_load;
    logic          alu_en;  // alu result onto data bus
    alu_fn_e       alu_fn;
  } ctrl_bus_t;

  typedef struct packed {
    logic [`RELAY_DATA_W-1:0] a, b, c, d, m1, m2, x, y, j1, j2, inst;
    logic [`RELAY_ADDR_W-1:0] pc;
    ccr_t                     ccr;
  } panel_t;

endpackage

// File: hdl/relay_defs.svh
`ifndef RELAY_DEFS_SVH
`define RELAY_DEFS_SVH

// memory depth in bytes, address wraps modulo depth
`define RELAY_MEM_WORDS 1024

// bus widths
`define RELAY_DATA_W 8
`define RELAY_ADDR_W 16

// width of the FSA one-hot vectors
`define RELAY_STEPS 24

// abort points, in FSA steps
`define RELAY_LEN_SHORT 8
`define RELAY_LEN_MEM 12
`define RELAY_LEN_INC 14
`define RELAY_LEN_GOTO 24

`endif
